//--- Makefile
.PHONY: run clean

obj_dir/VvgaFrameTb: files.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --timescale 1ns/1ns --top-module vgaFrameTb -f files.f

run: obj_dir/VvgaFrameTb
	@out="$$(./obj_dir/VvgaFrameTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- files.f
rtl/vgaPkg.sv
rtl/apbPixelWriter.sv
rtl/frameBuffer.sv
rtl/displayTiming.sv
rtl/pixelFormatter.sv
rtl/vgaFrameTop.sv
verification/clockGen.sv
verification/vgaFrameTb.sv

//--- rtl/apbPixelWriter.sv
`timescale 1ns/1ns
`default_nettype none

module apbPixelWriter #(
	parameter int FRAME_PIXELS = 640 * 480
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [31:0]                   paddr,
	input  vgaPkg::apbWord                pwdata,
	output logic                          pready,
	output logic [31:0]                   prdata,
	output logic                          pslverr,
	output logic                          writeEnable,
	output logic [vgaPkg::INDEX_BITS-1:0] writeIndex,
	output vgaPkg::pixel565               writePixel,
	output vgaPkg::controlReg             control
);

	localparam int FRAME_WORDS = FRAME_PIXELS / 2;

	logic        access;
	logic        hitControl;
	logic        hitPixel;
	logic [31:0] pixelOffset;
	logic [29:0] wordIndex;
	logic        inFrame;
	logic        pairWrite;
	logic        accessError;
	logic        phase;

	assign access = psel && penable;

	// Address decode
	assign hitControl = paddr == vgaPkg::CONTROL_ADDR;
	assign hitPixel = paddr >= vgaPkg::PIXEL_BASE;
	assign pixelOffset = paddr - vgaPkg::PIXEL_BASE;
	assign wordIndex = pixelOffset[31:2];
	assign inFrame = {2'b00, wordIndex} < 32'(FRAME_WORDS);

	assign pairWrite = access && hitPixel && pwrite && inFrame;
	// Pixel reads and writes past the frame fail, as does anything unmapped
	assign accessError = hitPixel ? !(pwrite && inFrame) : !hitControl;

	// Pair writes wait one cycle, everything else answers at once
	assign pready = access && (!pairWrite || phase);
	assign pslverr = pready && accessError;
	assign prdata = (access && hitControl && !pwrite) ? control : '0;

	// Even pixel in the first access cycle, odd pixel in the second
	assign writeEnable = pairWrite;
	assign writeIndex = {wordIndex[vgaPkg::INDEX_BITS-2:0], phase};
	assign writePixel = pwdata.pixels[phase];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			phase <= 1'b0;
		end else if (pairWrite) begin
			phase <= !phase;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			control <= '0;
		end else if (access && hitControl && pwrite) begin
			control <= pwdata.control;
		end
	end

endmodule

`default_nettype wire

//--- rtl/displayTiming.sv
`timescale 1ns/1ns
`default_nettype none

module displayTiming #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input  logic              clock,
	input  logic              arstN,
	output vgaPkg::timingBeat beat
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_BITS = $clog2(H_TOTAL);
	localparam int V_BITS = $clog2(V_TOTAL);

	localparam logic [H_BITS-1:0] H_LAST = H_BITS'(H_TOTAL - 1);
	localparam logic [H_BITS-1:0] H_VISIBLE = H_BITS'(H_ACTIVE);
	localparam logic [H_BITS-1:0] H_SYNC_START = H_BITS'(H_ACTIVE + H_FRONT);
	localparam logic [H_BITS-1:0] H_SYNC_END = H_BITS'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [V_BITS-1:0] V_LAST = V_BITS'(V_TOTAL - 1);
	localparam logic [V_BITS-1:0] V_VISIBLE = V_BITS'(V_ACTIVE);
	localparam logic [V_BITS-1:0] V_SYNC_START = V_BITS'(V_ACTIVE + V_FRONT);
	localparam logic [V_BITS-1:0] V_SYNC_END = V_BITS'(V_ACTIVE + V_FRONT + V_SYNC);

	logic [H_BITS-1:0]             hCount;
	logic [V_BITS-1:0]             vCount;
	logic [vgaPkg::INDEX_BITS-1:0] pixelCount;
	logic                          lineEnd;
	logic                          frameEnd;
	logic                          visible;

	assign lineEnd = hCount == H_LAST;
	assign frameEnd = lineEnd && (vCount == V_LAST);
	assign visible = (hCount < H_VISIBLE) && (vCount < V_VISIBLE);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			vCount <= frameEnd ? '0 : vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// Linear index of the visible pixel, follows raster order
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pixelCount <= '0;
		end else if (frameEnd) begin
			pixelCount <= '0;
		end else if (visible) begin
			pixelCount <= pixelCount + 1'b1;
		end
	end

	always_comb begin
		beat.hsync = !((hCount >= H_SYNC_START) && (hCount < H_SYNC_END));
		beat.vsync = !((vCount >= V_SYNC_START) && (vCount < V_SYNC_END));
		beat.active = visible;
		beat.pixelIndex = pixelCount;
	end

endmodule

`default_nettype wire

//--- rtl/frameBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module frameBuffer #(
	parameter int FRAME_PIXELS = 640 * 480
) (
	input  logic                          clock,
	input  logic                          arstN,
	input  logic                          writeEnable,
	input  logic [vgaPkg::INDEX_BITS-1:0] writeIndex,
	input  vgaPkg::pixel565               writePixel,
	input  vgaPkg::timingBeat             beatIn,
	output vgaPkg::fetchBeat              beatOut
);

	localparam int ADDR_BITS = $clog2(FRAME_PIXELS);

	vgaPkg::pixel565 pixels [FRAME_PIXELS];
	vgaPkg::pixel565 pixelReg;
	vgaPkg::timingBeat timingReg;
	logic [ADDR_BITS-1:0] readIndex;

	// Blank beats point past the last pixel, keep the read in range
	assign readIndex = beatIn.active ? beatIn.pixelIndex[ADDR_BITS-1:0] : '0;

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			pixels[writeIndex[ADDR_BITS-1:0]] <= writePixel;
		end
		pixelReg <= pixels[readIndex];
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			timingReg <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, pixelIndex: '0};
		end else begin
			timingReg <= beatIn;
		end
	end

	assign beatOut = '{timing: timingReg, pixel: pixelReg};

endmodule

`default_nettype wire

//--- rtl/pixelFormatter.sv
`timescale 1ns/1ns
`default_nettype none

module pixelFormatter (
	input  logic              clock,
	input  logic              arstN,
	input  vgaPkg::fetchBeat  beatIn,
	input  vgaPkg::controlReg control,
	output logic              hsync,
	output logic              vsync,
	output logic              blankN,
	output vgaPkg::rgb888     rgb
);

	vgaPkg::pixel565 source;

	// Fill the low bits by repeating the top ones
	function automatic vgaPkg::rgb888 expand(input vgaPkg::pixel565 p);
		vgaPkg::rgb888 c;
		c.red = {p.red, p.red[4:2]};
		c.green = {p.green, p.green[5:4]};
		c.blue = {p.blue, p.blue[4:2]};
		return c;
	endfunction

	// Disabled display shows the background color
	assign source = control.displayEnable ? beatIn.pixel : control.background;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blankN <= 1'b0;
			rgb <= '0;
		end else begin
			hsync <= beatIn.timing.hsync;
			vsync <= beatIn.timing.vsync;
			blankN <= beatIn.timing.active;
			rgb <= beatIn.timing.active ? expand(source) : '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/vgaFrameTop.sv
`timescale 1ns/1ns
`default_nettype none

module vgaFrameTop #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input  logic           clock,
	input  logic           arstN,
	// APB
	input  logic           psel,
	input  logic           penable,
	input  logic           pwrite,
	input  logic [31:0]    paddr,
	input  vgaPkg::apbWord pwdata,
	output logic           pready,
	output logic [31:0]    prdata,
	output logic           pslverr,
	// Display
	output logic           hsync,
	output logic           vsync,
	output logic           blankN,
	output vgaPkg::rgb888  rgb
);

	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

	logic                          writeEnable;
	logic [vgaPkg::INDEX_BITS-1:0] writeIndex;
	vgaPkg::pixel565               writePixel;
	vgaPkg::controlReg             control;
	vgaPkg::timingBeat             timingBeat;
	vgaPkg::fetchBeat              fetchBeat;

	apbPixelWriter #(
		.FRAME_PIXELS(FRAME_PIXELS)
	) writer (
		.clock(clock),
		.arstN(arstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writePixel(writePixel),
		.control(control)
	);

	displayTiming #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) timing (
		.clock(clock),
		.arstN(arstN),
		.beat(timingBeat)
	);

	frameBuffer #(
		.FRAME_PIXELS(FRAME_PIXELS)
	) fetch (
		.clock(clock),
		.arstN(arstN),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writePixel(writePixel),
		.beatIn(timingBeat),
		.beatOut(fetchBeat)
	);

	pixelFormatter format (
		.clock(clock),
		.arstN(arstN),
		.beatIn(fetchBeat),
		.control(control),
		.hsync(hsync),
		.vsync(vsync),
		.blankN(blankN),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- rtl/vgaPkg.sv
package vgaPkg;

	// Width of a linear pixel index, enough for 640x480
	localparam int INDEX_BITS = 20;

	localparam logic [31:0] CONTROL_ADDR = 32'h0000_0000;
	localparam logic [31:0] PIXEL_BASE = 32'h0000_1000;

	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} pixel565;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb888;

	typedef struct packed {
		logic displayEnable;
		logic [14:0] reserved;
		pixel565 background;
	} controlReg;

	// Pixel region uses the pair view, control address the register view
	typedef union packed {
		pixel565 [1:0] pixels;
		controlReg control;
	} apbWord;

	// Sync levels are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
		logic [INDEX_BITS-1:0] pixelIndex;
	} timingBeat;

	typedef struct packed {
		timingBeat timing;
		pixel565 pixel;
	} fetchBeat;

endpackage

//--- verification/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic arstN
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = !clock;
	end

	// Release on a rising edge so the first real update comes one cycle later
	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		arstN <= 1'b1;
	end

endmodule

//--- verification/vgaCases.txt
# op     address   data      pslverr  prdata
# data: hex, rand (random pixel pair) or bg (random background, display off)
# pslverr, prdata: hex, model (control register model) or - (not checked)
write    00000000  80000000  0        -
write    00001000  rand      0        -
write    00001004  rand      0        -
write    00001008  rand      0        -
write    0000100c  rand      0        -
write    00001010  rand      0        -
write    00001014  rand      0        -
read     00000000  0         0        80000000
frame    0         0         -        -
write    00000000  bg        0        -
read     00000000  0         0        model
frame    0         0         -        -
write    00000000  0000a5f3  0        -
read     00000000  0         0        0000a5f3
write    00000000  80000000  0        -
write    00001018  rand      1        -
read     00001000  0         1        -
read     00001014  0         1        -
write    00000004  12345678  1        -
read     00000ffc  0         1        -
frame    0         0         -        -
write    0000101c  rand      1        -
write    00000000  8000f81f  0        -
read     00000000  0         0        model
write    00001004  rand      0        -
frame    0         0         -        -

//--- verification/vgaFrameTb.sv
`timescale 1ns/1ns

module vgaFrameTb;

	localparam int H_ACTIVE = 4;
	localparam int V_ACTIVE = 3;
	localparam int V_TOTAL = V_ACTIVE + 1 + 1 + 1;
	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
	localparam int INDEX_W = $clog2(FRAME_PIXELS);
	localparam int WAIT_LIMIT = 20;
	localparam int FRAME_LIMIT = 200;

	logic           clock;
	logic           arstN;
	logic           psel;
	logic           penable;
	logic           pwrite;
	logic [31:0]    paddr;
	vgaPkg::apbWord pwdata;
	logic           pready;
	logic [31:0]    prdata;
	logic           pslverr;
	logic           hsync;
	logic           vsync;
	logic           blankN;
	vgaPkg::rgb888  rgb;

	logic [15:0] modelPixels [FRAME_PIXELS];
	logic [31:0] modelControl;
	int          errorCount;
	int          passCount;
	int          failCount;

	clockGen clocks (.clock(clock), .arstN(arstN));

	vgaFrameTop #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(1), .H_SYNC(2), .H_BACK(1),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(1), .V_SYNC(1), .V_BACK(1)
	) UUT (
		.clock(clock), .arstN(arstN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pready(pready), .prdata(prdata), .pslverr(pslverr),
		.hsync(hsync), .vsync(vsync), .blankN(blankN), .rgb(rgb)
	);

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	// Expand 565 to 888 by repeating the top bits
	function automatic logic [23:0] expandColor(input logic [15:0] p);
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
		r = p[15:11];
		g = p[10:5];
		b = p[4:0];
		return {r, r[4:2], g, g[5:4], b, b[4:2]};
	endfunction

	task automatic apbAccess(input logic write, input logic [31:0] addr, input logic [31:0] data,
			output logic err, output logic [31:0] rdata);
		int   cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		err = 1'b0;
		rdata = '0;
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			if (pready) begin
				done = 1'b1;
				err = pslverr;
				rdata = prdata;
			end
			cycles++;
		end
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
		if (!done) begin
			$display("Timeout: no pready for the access to address %h", addr);
			errorCount++;
		end
	endtask

	task automatic waitVsync(input logic level, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < FRAME_LIMIT) begin
			@(negedge clock);
			ok = (vsync == level);
			cycles++;
		end
		if (!ok) begin
			$display("Timeout: vsync never reached level %0d", level);
			errorCount++;
		end
	endtask

	// Pixel pairs inside the frame land at index (addr - base) / 2
	task automatic applyModel(input logic write, input logic [31:0] addr, input logic [31:0] data);
		logic [31:0]        word;
		logic [INDEX_W-1:0] evenIdx;
		word = (addr - vgaPkg::PIXEL_BASE) >> 2;
		evenIdx = INDEX_W'(word << 1);
		if (write && addr == vgaPkg::CONTROL_ADDR) begin
			modelControl = data;
		end else if (write && addr >= vgaPkg::PIXEL_BASE && word < 32'(FRAME_PIXELS / 2)) begin
			modelPixels[evenIdx] = data[15:0];
			modelPixels[evenIdx + 1'b1] = data[31:16];
		end
	endtask

	task automatic checkFrame();
		logic               ok;
		logic               seenLow;
		logic               lastHsync;
		logic [15:0]        source;
		logic [INDEX_W-1:0] idx;
		int                 cycles;
		int                 activeCount;
		int                 hsyncPulses;
		waitVsync(1'b0, ok);
		if (ok) begin
			waitVsync(1'b1, ok);
		end
		if (ok) begin
			seenLow = 1'b0;
			lastHsync = hsync;
			cycles = 0;
			activeCount = 0;
			hsyncPulses = 0;
			// One whole frame period up to the end of the next vsync pulse
			while (!(seenLow && vsync) && cycles < FRAME_LIMIT) begin
				if (blankN && activeCount < FRAME_PIXELS) begin
					idx = INDEX_W'(activeCount);
					source = modelControl[31] ? modelPixels[idx] : modelControl[15:0];
					checkValue($sformatf("rgb[%0d]", activeCount), {8'h00, rgb},
						{8'h00, expandColor(source)});
				end else if (!blankN) begin
					checkValue("rgb during blank", {8'h00, rgb}, 32'h0);
				end
				activeCount += blankN ? 1 : 0;
				hsyncPulses += (lastHsync && !hsync) ? 1 : 0;
				lastHsync = hsync;
				seenLow = seenLow || !vsync;
				cycles++;
				@(negedge clock);
			end
			if (cycles >= FRAME_LIMIT) begin
				$display("Timeout: frame did not end within %0d cycles", FRAME_LIMIT);
				errorCount++;
			end
			checkValue("active cycles", activeCount, FRAME_PIXELS);
			checkValue("hsync pulses", hsyncPulses, V_TOTAL);
		end
	endtask

	task automatic runCase(input string op, input logic [31:0] addr, input string dataTok,
			input string errTok, input string rdataTok);
		logic [31:0] data;
		logic [31:0] rnd;
		logic [31:0] expected;
		logic [31:0] rdata;
		logic        err;
		rnd = $urandom();
		data = '0;
		if (dataTok == "rand") begin
			data = rnd;
		end else if (dataTok == "bg") begin
			data = {16'h0000, rnd[15:0]};
		end else begin
			void'($sscanf(dataTok, "%h", data));
		end
		if (op == "write" || op == "read") begin
			apbAccess(op == "write", addr, data, err, rdata);
			if (errTok != "-") begin
				void'($sscanf(errTok, "%h", expected));
				checkValue("pslverr", {31'h0, err}, expected);
			end
			if (rdataTok != "-") begin
				expected = modelControl;
				if (rdataTok != "model") begin
					void'($sscanf(rdataTok, "%h", expected));
				end
				checkValue("prdata", rdata, expected);
			end
			applyModel(op == "write", addr, data);
		end else if (op == "frame") begin
			checkFrame();
		end else begin
			$display("Unknown operation %s in the case file", op);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("%s: pass", name);
		end else begin
			failCount++;
			$display("%s: fail", name);
		end
	endtask

	initial begin
		int          fd;
		int          fields;
		int          caseNumber;
		int          errorsBefore;
		int          cycles;
		string       line;
		string       op;
		string       dataTok;
		string       errTok;
		string       rdataTok;
		logic [31:0] addr;
		void'($urandom(38));
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		modelControl = '0;
		foreach (modelPixels[i]) modelPixels[i] = '0;
		caseNumber = 0;

		// Sample right after release, before the first clocked update
		errorsBefore = errorCount;
		cycles = 0;
		while (arstN !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (arstN !== 1'b1) begin
			$display("Timeout: reset was never released");
			errorCount++;
		end
		checkValue("pready", {31'h0, pready}, 32'h0);
		checkValue("pslverr", {31'h0, pslverr}, 32'h0);
		checkValue("hsync", {31'h0, hsync}, 32'h1);
		checkValue("vsync", {31'h0, vsync}, 32'h1);
		checkValue("blankN", {31'h0, blankN}, 32'h0);
		checkValue("rgb", {8'h00, rgb}, 32'h0);
		reportTest("reset state", errorsBefore);

		fd = $fopen("verification/vgaCases.txt", "r");
		if (fd == 0) begin
			$display("Could not open verification/vgaCases.txt");
			errorCount++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s %h %s %s %s", op, addr, dataTok, errTok, rdataTok);
				if (fields == 5 && op != "#") begin
					caseNumber++;
					errorsBefore = errorCount;
					runCase(op, addr, dataTok, errTok, rdataTok);
					reportTest($sformatf("case %0d %s %h", caseNumber, op, addr), errorsBefore);
				end
			end
			$fclose(fd);
		end

		$display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
